/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // ~~~~~~~~~~~~~~~~~~~~
    // only J and B change the flow, every other opcode falls through to pc plus 4.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,               // register ops.
        OP_J       = 6'h02,               // absolute jump.
        OP_B       = 6'h04,               // beq $0, $0, always taken.
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } op_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // instruction formats
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        op_e         op;                  // 31:26.
        logic [25:0] target;              // word target inside the 256 MB region.
    } j_fmt_t;

    typedef struct packed {
        op_e                op;           // 31:26.
        logic [4:0]         rs;           // 25:21.
        logic [4:0]         rt;           // 20:16.
        logic signed [15:0] offset;       // word offset from pc plus 4.
    } i_fmt_t;

    // one fetched word, seen as a jump or as a branch by the opcode.
    typedef union packed {
        j_fmt_t j;
        i_fmt_t i;
    } inst_u;

endpackage

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] pc_t;            // byte address.

    localparam pc_t RESET_PC = 32'h0000_0000;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage buses
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        pc_t pc;
        pc_t pred_npc;                    // where pc_gen went next.
    } ps_to_fs_t;

    typedef struct packed {
        pc_t           pc;
        isa_pkg::inst_u inst;
        pc_t           pred_npc;
    } fs_to_ds_t;

    typedef struct packed {
        logic en;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        pc_t           pc;
        isa_pkg::inst_u inst;
    } retire_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // predictor
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int BTB_IDX_W = 4;
    localparam int BTB_TAG_W = 32 - BTB_IDX_W - 2;

    typedef struct packed {
        logic en;
        pc_t  pc;                         // pc of the J or B.
        pc_t  target;                     // resolved target.
    } bp_update_t;

    typedef struct packed {
        logic [BTB_TAG_W-1:0] tag;
        pc_t                  target;
    } btb_entry_t;

endpackage

`default_nettype wire

/* hdl/pc_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_allowin,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  bp_hit,
    input  fetch_pkg::pc_t        bp_target,
    output fetch_pkg::pc_t        lookup_pc,
    output logic                  ps_valid,
    output fetch_pkg::ps_to_fs_t  ps_bus
);

    fetch_pkg::pc_t pc_q;                 // address on offer to fetch.
    logic           valid_q;
    fetch_pkg::pc_t pred_npc;
    logic           ps_go;

    // the btb answers in the same cycle.
    assign lookup_pc = pc_q;
    assign pred_npc  = bp_hit ? bp_target : pc_q + 32'd4;

    assign ps_go    = valid_q && fs_allowin;   // fetch takes the address.
    assign ps_valid = valid_q;
    assign ps_bus   = '{pc: pc_q, pred_npc: pred_npc};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;              // one idle cycle out of reset.
        end
    end

    // a redirect from decode wins over the prediction.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect.en) begin
            pc_q <= redirect.target;
        end else if (ps_go) begin
            pc_q <= pred_npc;
        end
    end

endmodule

`default_nettype wire

/* hdl/branch_predictor.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::pc_t         lookup_pc,
    output logic                   hit,
    output fetch_pkg::pc_t         target,
    input  fetch_pkg::bp_update_t  update
);

    localparam int IDX_W   = fetch_pkg::BTB_IDX_W;
    localparam int TAG_W   = fetch_pkg::BTB_TAG_W;
    localparam int ENTRIES = 2 ** IDX_W;

    logic [ENTRIES-1:0]    valid_q;
    fetch_pkg::btb_entry_t btb_q [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    // ~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~
    assign rd_idx = lookup_pc[IDX_W+1:2];
    assign rd_tag = lookup_pc[31:IDX_W+2];

    assign hit    = valid_q[rd_idx] && (btb_q[rd_idx].tag == rd_tag);
    assign target = btb_q[rd_idx].target;      // only meaningful on a hit.

    // ~~~~~~~~~~~~~~~~~~~~
    // update
    // ~~~~~~~~~~~~~~~~~~~~
    assign wr_idx = update.pc[IDX_W+1:2];
    assign wr_tag = update.pc[31:IDX_W+2];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;                // all entries start invalid.
        end else if (update.en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // an aliasing pc simply replaces the old entry.
    always_ff @(posedge clk) begin
        if (update.en) begin
            btb_q[wr_idx] <= '{tag: wr_tag, target: update.target};
        end
    end

endmodule

`default_nettype wire

/* hdl/inst_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            load_en,
    input  fetch_pkg::pc_t  load_addr,
    input  logic [31:0]     load_data,
    input  fetch_pkg::pc_t  rd_addr,
    output isa_pkg::inst_u  rd_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];

    // word index, upper address bits wrap.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[IDX_W+1:2]] <= load_data;
        end
    end

    assign rd_data = mem[rd_addr[IDX_W+1:2]];   // asynchronous read.

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ps_valid,
    input  fetch_pkg::ps_to_fs_t  ps_bus,
    output logic                  fs_allowin,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  ds_allowin,
    output fetch_pkg::pc_t        mem_addr,
    input  isa_pkg::inst_u        mem_data,
    output logic                  fs_valid_out,
    output fetch_pkg::fs_to_ds_t  fs_bus
);

    logic                 fs_valid;
    fetch_pkg::ps_to_fs_t ps_bus_r;       // buffered pc and prediction.

    // ~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~
    assign fs_allowin   = !fs_valid || ds_allowin;   // no cache stall here.
    assign fs_valid_out = fs_valid;

    // the item under decode turned out wrong, so drop what is behind it.
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (redirect.en) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= ps_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ps_valid && fs_allowin) begin
            ps_bus_r <= ps_bus;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // memory read
    // ~~~~~~~~~~~~~~~~~~~~
    assign mem_addr = ps_bus_r.pc;

    assign fs_bus = '{
        pc:       ps_bus_r.pc,
        inst:     mem_data,
        pred_npc: ps_bus_r.pred_npc
    };

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_valid,
    input  fetch_pkg::fs_to_ds_t   fs_bus,
    output logic                   ds_allowin,
    output fetch_pkg::redirect_t   redirect,
    output fetch_pkg::bp_update_t  bp_update,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fetch_pkg::retire_t     out_data
);

    isa_pkg::inst_u     inst;
    fetch_pkg::pc_t     seq_pc;
    fetch_pkg::pc_t     true_npc;
    logic               is_j;
    logic               is_b;
    logic               ds_accept;
    logic               out_valid_q;
    fetch_pkg::retire_t out_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // next pc
    // ~~~~~~~~~~~~~~~~~~~~
    assign inst   = fs_bus.inst;
    assign seq_pc = fs_bus.pc + 32'd4;
    assign is_j   = (inst.j.op == isa_pkg::OP_J);
    assign is_b   = (inst.i.op == isa_pkg::OP_B);

    always_comb begin
        if (is_j) begin
            true_npc = {seq_pc[31:28], inst.j.target, 2'b00};   // region of the delay pc.
        end else if (is_b) begin
            true_npc = seq_pc + {{14{inst.i.offset[15]}}, inst.i.offset, 2'b00};
        end else begin
            true_npc = seq_pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~
    assign ds_allowin = !out_valid_q || out_ready;
    assign ds_accept  = fs_valid && ds_allowin;

    // flow checks happen once, as the word enters decode.
    assign redirect = '{
        en:     ds_accept && (true_npc != fs_bus.pred_npc),
        target: true_npc
    };

    assign bp_update = '{
        en:     ds_accept && (is_j || is_b),
        pc:     fs_bus.pc,
        target: true_npc
    };

    // ~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= 1'b0;
        end else if (ds_accept) begin
            out_valid_q <= 1'b1;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;          // taken, nothing behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (ds_accept) begin
            out_q <= '{pc: fs_bus.pc, inst: fs_bus.inst};
        end
    end

    assign out_valid = out_valid_q;
    assign out_data  = out_q;

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_en,
    input  fetch_pkg::pc_t      load_addr,
    input  logic [31:0]         load_data,
    output logic                out_valid,
    output fetch_pkg::retire_t  out_data,
    input  logic                out_ready
);

    fetch_pkg::pc_t        lookup_pc;
    logic                  bp_hit;
    fetch_pkg::pc_t        bp_target;
    fetch_pkg::bp_update_t bp_update;
    fetch_pkg::redirect_t  redirect;

    logic                  ps_valid;
    fetch_pkg::ps_to_fs_t  ps_bus;
    logic                  fs_allowin;
    logic                  fs_valid;
    fetch_pkg::fs_to_ds_t  fs_bus;
    logic                  ds_allowin;

    fetch_pkg::pc_t        mem_addr;
    isa_pkg::inst_u        mem_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // front end
    // ~~~~~~~~~~~~~~~~~~~~
    pc_gen u_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .fs_allowin (fs_allowin),
        .redirect   (redirect),
        .bp_hit     (bp_hit),
        .bp_target  (bp_target),
        .lookup_pc  (lookup_pc),
        .ps_valid   (ps_valid),
        .ps_bus     (ps_bus)
    );

    branch_predictor u_branch_predictor (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (lookup_pc),
        .hit       (bp_hit),
        .target    (bp_target),
        .update    (bp_update)
    );

    inst_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_inst_mem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (mem_addr),
        .rd_data   (mem_data)
    );

    fetch_stage u_fetch_stage (
        .clk          (clk),
        .reset        (reset),
        .ps_valid     (ps_valid),
        .ps_bus       (ps_bus),
        .fs_allowin   (fs_allowin),
        .redirect     (redirect),
        .ds_allowin   (ds_allowin),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .fs_valid_out (fs_valid),
        .fs_bus       (fs_bus)
    );

    decode_stage u_decode_stage (
        .clk        (clk),
        .reset      (reset),
        .fs_valid   (fs_valid),
        .fs_bus     (fs_bus),
        .ds_allowin (ds_allowin),
        .redirect   (redirect),
        .bp_update  (bp_update),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

/* verif/fetch_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_assertions #(
    parameter int DATA_W = 32
) (
    input logic              clk,
    input logic              reset,
    input logic              valid,
    input logic              ready,
    input logic [DATA_W-1:0] data
);

    // an item that was not taken stays put.
    held_stable: assert property (
        @(posedge clk) disable iff (reset)
        valid && !ready |=> valid && $stable(data)
    ) else $error("held item changed or vanished under back-pressure");

    idle_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !valid
    ) else $error("valid high in the first cycle after reset");

endmodule

// ~~~~~~~~~~~~~~~~~~~~
// stage hookup
// ~~~~~~~~~~~~~~~~~~~~
bind fetch_stage fetch_assertions #(
    .DATA_W ($bits(fetch_pkg::fs_to_ds_t))
) u_fetch_stage_assertions (
    .clk   (clk),
    .reset (reset),
    .valid (fs_valid_out),
    .ready (ds_allowin),
    .data  (fs_bus)
);

bind decode_stage fetch_assertions #(
    .DATA_W ($bits(fetch_pkg::retire_t))
) u_decode_stage_assertions (
    .clk   (clk),
    .reset (reset),
    .valid (out_valid),
    .ready (out_ready),
    .data  (out_data)
);

`default_nettype wire

/* verif/fetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

    localparam int          MEM_WORDS       = 256;
    localparam int          IDX_W           = $clog2(MEM_WORDS);
    localparam int          NUM_INST        = 400;
    localparam int          CYCLES_PER_INST = 8;
    localparam int          RESET_CYCLES    = 2;
    localparam int          TIMEOUT_CYCLES  = RESET_CYCLES + MEM_WORDS + 1
                                              + NUM_INST * CYCLES_PER_INST;
    localparam logic [31:0] SEED            = 32'h7e93_edb1;

    logic               clk = 1'b0;
    logic               reset;
    logic               load_en;
    fetch_pkg::pc_t     load_addr;
    logic [31:0]        load_data;
    logic               out_valid;
    fetch_pkg::retire_t out_data;
    logic               out_ready;

    logic [31:0]    image [MEM_WORDS];    // program as loaded.
    logic [31:0]    lfsr_state;
    fetch_pkg::pc_t model_pc    = fetch_pkg::RESET_PC;
    int             errors      = 0;
    int             retired     = 0;
    int             cycle_count = 0;

    fetch_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_fetch_top (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;                 // 4 ns period.

    // ~~~~~~~~~~~~~~~~~~~~
    // random source
    // ~~~~~~~~~~~~~~~~~~~~
    // x^32 + x^22 + x^2 + x + 1, shifting right.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          b;
        v = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};  // one step per bit.
        end
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // program and model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] make_word(input int idx);
        isa_pkg::inst_u w;
        logic [31:0]    sel;
        logic [31:0]    pick;
        int             t;
        sel = rand_bits(3);
        if (sel == 32'd0) begin
            w.j.op     = isa_pkg::OP_J;
            w.j.target = 26'(rand_bits(IDX_W));       // word index inside memory.
        end else if (sel == 32'd1) begin
            t          = int'(rand_bits(IDX_W));
            w.i.op     = isa_pkg::OP_B;
            w.i.rs     = 5'd0;
            w.i.rt     = 5'd0;
            w.i.offset = 16'(t - (idx + 1));          // lands on word t.
        end else begin
            w.j.target = 26'(rand_bits(26));
            pick       = rand_bits(3);
            case (pick[2:0])
                3'd0:    w.j.op = isa_pkg::OP_SPECIAL;
                3'd1:    w.j.op = isa_pkg::OP_ADDIU;
                3'd2:    w.j.op = isa_pkg::OP_ORI;
                3'd3:    w.j.op = isa_pkg::OP_LUI;
                3'd4:    w.j.op = isa_pkg::OP_LW;
                3'd5:    w.j.op = isa_pkg::OP_SW;
                3'd6:    w.j.op = isa_pkg::OP_ADDIU;
                default: w.j.op = isa_pkg::OP_ORI;
            endcase
        end
        return w;
    endfunction

    // architectural successor of one instruction.
    function automatic fetch_pkg::pc_t next_arch_pc(input fetch_pkg::pc_t pc,
                                                    input isa_pkg::inst_u w);
        fetch_pkg::pc_t seq;
        seq = pc + 32'd4;
        case (w.j.op)
            isa_pkg::OP_J: return {seq[31:28], w.j.target, 2'b00};
            isa_pkg::OP_B: return seq + 32'(w.i.offset) * 32'd4;
            default:       return seq;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic expect_retire(input string name, input fetch_pkg::retire_t exp,
                                 input fetch_pkg::retire_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected pc %h inst %h, actual pc %h inst %h",
                     name, exp.pc, exp.inst, act.pc, act.inst);
        end
    endtask

    task automatic check_word(input string name, input isa_pkg::inst_u exp,
                              input isa_pkg::inst_u act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s word: expected %h, actual %h", name, exp, act);
        end
    endtask

    initial begin : stimulus
        int                 i;
        logic [31:0]        rnd;
        fetch_pkg::retire_t exp_r;
        fetch_pkg::retire_t held_data;
        logic               hold_pending;
        logic               first_cycle;
        string              name;
        reset     <= 1'b1;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        out_ready <= 1'b0;
        lfsr_state = SEED;
        for (i = 0; i < MEM_WORDS; i++) begin
            image[i] = make_word(i);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        // the pipeline stays idle while the program goes in.
        for (i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i * 4;
            load_data <= image[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        reset   <= 1'b0;

        first_cycle  = 1'b1;
        hold_pending = 1'b0;
        held_data    = '0;
        while (retired < NUM_INST) begin
            @(posedge clk);
            if (first_cycle && out_valid) begin
                errors++;
                $display("out_valid was high in the first cycle after reset");
            end
            first_cycle = 1'b0;
            if (hold_pending && !out_valid) begin
                errors++;
                $display("out_valid dropped while the output was held");
            end else if (hold_pending) begin
                expect_retire("held output", held_data, out_data);
            end
            if (out_valid && out_ready) begin
                name       = $sformatf("retire %0d", retired);
                exp_r.pc   = model_pc;
                exp_r.inst = image[model_pc[IDX_W+1:2]];
                expect_retire(name, exp_r, out_data);
                check_word(name, image[out_data.pc[IDX_W+1:2]], out_data.inst);
                model_pc = next_arch_pc(model_pc, exp_r.inst);
                retired++;
            end
            hold_pending = out_valid && !out_ready;
            held_data    = out_data;
            rnd = rand_bits(1);
            out_ready <= rnd[0];          // random back-pressure.
        end

        $display("errors: %0d, retired %0d of %0d", errors, retired, NUM_INST);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycle_count, retired, NUM_INST);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/branch_predictor.sv
hdl/inst_mem.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/fetch_top.sv
verif/fetch_assertions.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run fetch_tb with Verilator, then judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module fetch_tb -f build.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0
